//--- Bender.yml
package:
  name: ooo_core

sources:
  - ooo_pkg.sv
  - reg_status_file.sv
  - dispatcher.sv
  - reorder_buffer.sv
  - reservation_station.sv
  - exec_unit.sv
  - cdb_arbiter.sv
  - ooo_core.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_ooo_core.sv

//--- cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter (
    input  ooo_pkg::cdb_t mult_req,
    input  ooo_pkg::cdb_t alu_req,
    output logic          mult_grant,
    output logic          alu_grant,
    output ooo_pkg::cdb_t cdb
);

    // multiplier wins since it has the longer pipeline to stall
    assign mult_grant = mult_req.valid;
    assign alu_grant  = alu_req.valid && !mult_req.valid;

    always_comb begin
        if (mult_grant) begin
            cdb = mult_req;
        end else if (alu_grant) begin
            cdb = alu_req;
        end else begin
            cdb = '0;
        end
    end

endmodule

//--- dispatcher.sv
`timescale 1ns/1ps

module dispatcher (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                inst_valid,
    input  ooo_pkg::decoded_pack_t              inst,
    output logic                                inst_ready,
    output logic [ooo_pkg::reg_addr_len-1:0]    src1_addr,
    output logic [ooo_pkg::reg_addr_len-1:0]    src2_addr,
    input  ooo_pkg::operand_t                   src1_stat,
    input  ooo_pkg::operand_t                   src2_stat,
    output logic [ooo_pkg::rob_tag_len-1:0]     rob_tag1,
    output logic [ooo_pkg::rob_tag_len-1:0]     rob_tag2,
    input  ooo_pkg::operand_t                   rob_val1,
    input  ooo_pkg::operand_t                   rob_val2,
    output ooo_pkg::rob_alloc_t                 alloc,
    input  logic [ooo_pkg::rob_tag_len-1:0]     alloc_tag,
    input  logic                                rob_full,
    input  ooo_pkg::cdb_t                       cdb,
    output logic                                alu_entry_valid,
    output logic                                mult_entry_valid,
    output ooo_pkg::rs_entry_t                  entry,
    input  logic                                alu_full,
    input  logic                                mult_full
);

    logic                   hold_valid;
    ooo_pkg::decoded_pack_t hold;
    logic                   target_full;
    logic                   fire;

    // register first, then ROB, then a same-cycle broadcast
    function automatic ooo_pkg::operand_t resolve(input ooo_pkg::operand_t reg_stat,
                                                  input ooo_pkg::operand_t rob_stat,
                                                  input ooo_pkg::cdb_t     bus);
        ooo_pkg::operand_t res;
        res = reg_stat;
        if (!reg_stat.ready) begin
            if (rob_stat.ready) begin
                res.ready = 1'b1;
                res.value = rob_stat.value;
            end else if (bus.valid && bus.tag == reg_stat.tag) begin
                res.ready = 1'b1;
                res.value = bus.value;
            end else begin
                res.value = '0;
            end
        end
        return res;
    endfunction

    assign target_full = (hold.fu == ooo_pkg::fu_mult) ? mult_full : alu_full;
    assign fire        = hold_valid && !rob_full && !target_full;
    assign inst_ready  = !hold_valid || fire;

    always_ff @(posedge clk) begin
        if (reset) begin
            hold_valid <= 1'b0;
        end else if (inst_ready) begin
            hold_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_ready && inst_valid) begin
            hold <= inst;
        end
    end

    assign src1_addr = hold.src1;
    assign src2_addr = hold.src2;
    assign rob_tag1  = src1_stat.tag;
    assign rob_tag2  = src2_stat.tag;

    always_comb begin
        entry.op       = hold.op;
        entry.dest_tag = alloc_tag;
        entry.src1     = resolve(src1_stat, rob_val1, cdb);
        if (hold.imm_valid) begin
            entry.src2.ready = 1'b1;
            entry.src2.tag   = '0;
            entry.src2.value = hold.imm;
        end else begin
            entry.src2 = resolve(src2_stat, rob_val2, cdb);
        end
    end

    // steer by unit class
    assign alloc.valid      = fire;
    assign alloc.dest       = hold.dest;
    assign alu_entry_valid  = fire && (hold.fu == ooo_pkg::fu_alu);
    assign mult_entry_valid = fire && (hold.fu == ooo_pkg::fu_mult);

    // a waiting operand never names the entry it belongs to
    assert property (@(posedge clk) disable iff (reset)
        fire |-> (entry.src1.ready || entry.src1.tag != alloc_tag)
              && (entry.src2.ready || entry.src2.tag != alloc_tag));

endmodule

//--- exec_unit.sv
`timescale 1ns/1ps

module exec_unit #(
    parameter int latency = 1
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                issue_valid,
    input  ooo_pkg::exec_req_t  issue,
    output logic                ready,
    output ooo_pkg::cdb_t       req,
    input  logic                grant
);

    ooo_pkg::cdb_t pipe [latency];
    ooo_pkg::cdb_t result;
    logic          stall;

    always_comb begin
        result.valid = issue_valid;
        result.tag   = issue.dest_tag;
        case (issue.op)
            ooo_pkg::op_add: result.value = issue.val1 + issue.val2;
            ooo_pkg::op_sub: result.value = issue.val1 - issue.val2;
            ooo_pkg::op_and: result.value = issue.val1 & issue.val2;
            ooo_pkg::op_or:  result.value = issue.val1 | issue.val2;
            ooo_pkg::op_xor: result.value = issue.val1 ^ issue.val2;
            ooo_pkg::op_slt: begin
                result.value = {{(ooo_pkg::xlen-1){1'b0}},
                                $signed(issue.val1) < $signed(issue.val2)};
            end
            // low half of the product
            ooo_pkg::op_mul: result.value = issue.val1 * issue.val2;
            default:         result.value = '0;
        endcase
    end

    // a finished result waiting for the bus freezes every stage
    assign stall = pipe[latency-1].valid && !grant;
    assign ready = !stall;
    assign req   = pipe[latency-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < latency; k++) begin
                pipe[k].valid <= 1'b0;
            end
        end else if (!stall) begin
            pipe[0] <= result;
            for (int k = 1; k < latency; k++) begin
                pipe[k] <= pipe[k-1];
            end
        end
    end

endmodule

//--- ooo_core.f
ooo_pkg.sv
reg_status_file.sv
dispatcher.sv
reorder_buffer.sv
reservation_station.sv
exec_unit.sv
cdb_arbiter.sv
ooo_core.sv
tb_clock.sv
tb_ooo_core.sv

//--- ooo_core.sv
`timescale 1ns/1ps

module ooo_core #(
    parameter int rs_depth     = 4,
    parameter int alu_latency  = 1,
    parameter int mult_latency = 3
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inst_valid,
    input  ooo_pkg::decoded_pack_t inst,
    output logic                   inst_ready,
    output logic                   commit_valid,
    output ooo_pkg::commit_t       commit
);

    logic [ooo_pkg::reg_addr_len-1:0] src1_addr, src2_addr;
    ooo_pkg::operand_t                src1_stat, src2_stat;
    logic [ooo_pkg::rob_tag_len-1:0]  rob_tag1, rob_tag2;
    ooo_pkg::operand_t                rob_val1, rob_val2;
    ooo_pkg::rob_alloc_t              alloc;
    logic [ooo_pkg::rob_tag_len-1:0]  alloc_tag, commit_tag;
    logic                             rob_full;
    ooo_pkg::cdb_t                    cdb;
    logic                             alu_entry_valid, mult_entry_valid;
    ooo_pkg::rs_entry_t               entry;
    logic                             alu_full, mult_full;
    logic                             alu_issue_valid, mult_issue_valid;
    ooo_pkg::exec_req_t               alu_issue, mult_issue;
    logic                             alu_ready, mult_ready;
    ooo_pkg::cdb_t                    alu_req, mult_req;
    logic                             alu_grant, mult_grant;

    dispatcher u_dispatcher (
        .clk(clk), .reset(reset),
        .inst_valid(inst_valid), .inst(inst), .inst_ready(inst_ready),
        .src1_addr(src1_addr), .src2_addr(src2_addr),
        .src1_stat(src1_stat), .src2_stat(src2_stat),
        .rob_tag1(rob_tag1), .rob_tag2(rob_tag2),
        .rob_val1(rob_val1), .rob_val2(rob_val2),
        .alloc(alloc), .alloc_tag(alloc_tag), .rob_full(rob_full), .cdb(cdb),
        .alu_entry_valid(alu_entry_valid), .mult_entry_valid(mult_entry_valid),
        .entry(entry), .alu_full(alu_full), .mult_full(mult_full)
    );

    reg_status_file u_reg_status_file (
        .clk(clk), .reset(reset),
        .src1_addr(src1_addr), .src2_addr(src2_addr),
        .src1_stat(src1_stat), .src2_stat(src2_stat),
        .rename_valid(alloc.valid), .rename_dest(alloc.dest), .rename_tag(alloc_tag),
        .commit_valid(commit_valid), .commit(commit), .commit_tag(commit_tag)
    );

    reorder_buffer u_reorder_buffer (
        .clk(clk), .reset(reset),
        .alloc(alloc), .alloc_tag(alloc_tag), .full(rob_full),
        .rob_tag1(rob_tag1), .rob_tag2(rob_tag2),
        .rob_val1(rob_val1), .rob_val2(rob_val2), .cdb(cdb),
        .commit_valid(commit_valid), .commit(commit), .commit_tag(commit_tag)
    );

    reservation_station #(.rs_depth(rs_depth)) u_alu_rs (
        .clk(clk), .reset(reset),
        .entry_valid(alu_entry_valid), .entry(entry), .full(alu_full), .cdb(cdb),
        .issue_valid(alu_issue_valid), .issue(alu_issue), .unit_ready(alu_ready)
    );

    reservation_station #(.rs_depth(rs_depth)) u_mult_rs (
        .clk(clk), .reset(reset),
        .entry_valid(mult_entry_valid), .entry(entry), .full(mult_full), .cdb(cdb),
        .issue_valid(mult_issue_valid), .issue(mult_issue), .unit_ready(mult_ready)
    );

    exec_unit #(.latency(alu_latency)) u_alu (
        .clk(clk), .reset(reset),
        .issue_valid(alu_issue_valid), .issue(alu_issue), .ready(alu_ready),
        .req(alu_req), .grant(alu_grant)
    );

    exec_unit #(.latency(mult_latency)) u_mult (
        .clk(clk), .reset(reset),
        .issue_valid(mult_issue_valid), .issue(mult_issue), .ready(mult_ready),
        .req(mult_req), .grant(mult_grant)
    );

    cdb_arbiter u_cdb_arbiter (
        .mult_req(mult_req), .alu_req(alu_req),
        .mult_grant(mult_grant), .alu_grant(alu_grant), .cdb(cdb)
    );

endmodule

//--- ooo_core_stimulus.txt
# fu op dest src1 src2 imm imm_valid expected (all hex), then test number (decimal)
# fu 0 alu 1 mult, op 0 add 1 sub 2 and 3 or 4 xor 5 slt 6 mul
0 0 1 2 0 00000064 1 00000064 1
0 3 2 3 0 00001234 1 00001234 1
0 0 3 4 5 00000000 0 00000000 1
0 1 4 2 1 00000000 0 000011d0 2
0 2 5 2 0 00000f0f 1 00000204 2
0 3 6 1 2 00000000 0 00001274 2
0 4 7 1 0 ffffffff 1 ffffff9b 2
0 5 8 3 0 ffffffff 1 00000000 2
0 5 9 1 2 00000000 0 00000001 2
0 1 a 1 0 00000065 1 ffffffff 2
0 0 b a 0 00000002 1 00000001 3
0 0 b b b 00000000 0 00000002 3
0 4 c b 6 00000000 0 00001276 3
0 1 b c b 00000000 0 00001274 3
1 6 d 4 7 00000000 0 fff8f8f0 4
0 0 e 9 0 00000010 1 00000011 4
0 3 f 5 8 00000000 0 00000204 4
1 6 2 2 0 00000003 1 0000369c 5
1 6 2 2 0 00000003 1 0000a3d4 5
1 6 2 2 0 00000003 1 0001eb7c 5
1 6 2 2 0 00000003 1 0005c274 5
1 6 2 2 0 00000003 1 0011475c 5
1 6 2 2 0 00000003 1 0033d614 5
1 6 2 2 0 00000003 1 009b823c 5
1 6 2 2 0 00000003 1 01d286b4 5
1 6 2 2 0 00000003 1 0577941c 5
1 6 3 6 6 00000000 0 01548490 6
0 0 4 9 9 00000000 0 00000002 6
0 2 5 7 0 000000ff 1 0000009b 6
0 3 6 e 0 00000100 1 00000111 6

//--- ooo_pkg.sv
package ooo_pkg;

    localparam int xlen         = 32;
    localparam int reg_num      = 16;
    localparam int reg_addr_len = 4;
    localparam int rob_size     = 8;
    localparam int rob_tag_len  = 3;

    typedef enum logic {
        fu_alu,
        fu_mult
    } fu_t;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_mul
    } alu_op_t;

    // one instruction from decode, imm replaces src2 when imm_valid is set
    typedef struct packed {
        fu_t                     fu;
        alu_op_t                 op;
        logic [reg_addr_len-1:0] dest;
        logic [reg_addr_len-1:0] src1;
        logic [reg_addr_len-1:0] src2;
        logic [xlen-1:0]         imm;
        logic                    imm_valid;
    } decoded_pack_t;

    // value when ready, producing tag otherwise
    typedef struct packed {
        logic                   ready;
        logic [rob_tag_len-1:0] tag;
        logic [xlen-1:0]        value;
    } operand_t;

    typedef struct packed {
        alu_op_t                op;
        logic [rob_tag_len-1:0] dest_tag;
        operand_t               src1;
        operand_t               src2;
    } rs_entry_t;

    typedef struct packed {
        alu_op_t                op;
        logic [rob_tag_len-1:0] dest_tag;
        logic [xlen-1:0]        val1;
        logic [xlen-1:0]        val2;
    } exec_req_t;

    typedef struct packed {
        logic                   valid;
        logic [rob_tag_len-1:0] tag;
        logic [xlen-1:0]        value;
    } cdb_t;

    typedef struct packed {
        logic                    valid;
        logic [reg_addr_len-1:0] dest;
    } rob_alloc_t;

    typedef struct packed {
        logic [reg_addr_len-1:0] dest;
        logic [xlen-1:0]         value;
    } commit_t;

endpackage

//--- reg_status_file.sv
`timescale 1ns/1ps

module reg_status_file (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [ooo_pkg::reg_addr_len-1:0]    src1_addr,
    input  logic [ooo_pkg::reg_addr_len-1:0]    src2_addr,
    output ooo_pkg::operand_t                   src1_stat,
    output ooo_pkg::operand_t                   src2_stat,
    input  logic                                rename_valid,
    input  logic [ooo_pkg::reg_addr_len-1:0]    rename_dest,
    input  logic [ooo_pkg::rob_tag_len-1:0]     rename_tag,
    input  logic                                commit_valid,
    input  ooo_pkg::commit_t                    commit,
    input  logic [ooo_pkg::rob_tag_len-1:0]     commit_tag
);

    logic [ooo_pkg::xlen-1:0]        value_q [ooo_pkg::reg_num];
    logic [ooo_pkg::rob_tag_len-1:0] tag_q   [ooo_pkg::reg_num];
    logic [ooo_pkg::reg_num-1:0]     busy_q;

    // a busy register points at its producer in the ROB
    assign src1_stat.ready = !busy_q[src1_addr];
    assign src1_stat.tag   = tag_q[src1_addr];
    assign src1_stat.value = value_q[src1_addr];
    assign src2_stat.ready = !busy_q[src2_addr];
    assign src2_stat.tag   = tag_q[src2_addr];
    assign src2_stat.value = value_q[src2_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= '0;
            for (int i = 0; i < ooo_pkg::reg_num; i++) begin
                value_q[i] <= '0;
            end
        end else begin
            if (commit_valid) begin
                value_q[commit.dest] <= commit.value;
                // a younger producer keeps the register busy
                if (tag_q[commit.dest] == commit_tag) begin
                    busy_q[commit.dest] <= 1'b0;
                end
            end
            // rename is written last so it wins over the clear
            if (rename_valid) begin
                busy_q[rename_dest] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rename_valid) begin
            tag_q[rename_dest] <= rename_tag;
        end
    end

endmodule

//--- reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer (
    input  logic                                clk,
    input  logic                                reset,
    input  ooo_pkg::rob_alloc_t                 alloc,
    output logic [ooo_pkg::rob_tag_len-1:0]     alloc_tag,
    output logic                                full,
    input  logic [ooo_pkg::rob_tag_len-1:0]     rob_tag1,
    input  logic [ooo_pkg::rob_tag_len-1:0]     rob_tag2,
    output ooo_pkg::operand_t                   rob_val1,
    output ooo_pkg::operand_t                   rob_val2,
    input  ooo_pkg::cdb_t                       cdb,
    output logic                                commit_valid,
    output ooo_pkg::commit_t                    commit,
    output logic [ooo_pkg::rob_tag_len-1:0]     commit_tag
);

    logic [ooo_pkg::rob_tag_len-1:0]  head;
    logic [ooo_pkg::rob_tag_len-1:0]  tail;
    logic [ooo_pkg::rob_tag_len:0]    count;
    logic [ooo_pkg::rob_size-1:0]     done;
    logic [ooo_pkg::rob_size-1:0]     in_use;
    logic [ooo_pkg::reg_addr_len-1:0] dest_q  [ooo_pkg::rob_size];
    logic [ooo_pkg::xlen-1:0]         value_q [ooo_pkg::rob_size];

    // entry is live when its distance from head is below count
    always_comb begin
        for (int i = 0; i < ooo_pkg::rob_size; i++) begin
            in_use[i] = {1'b0, ooo_pkg::rob_tag_len'(i) - head} < count;
        end
    end

    assign alloc_tag = tail;
    assign full      = (count == (ooo_pkg::rob_tag_len + 1)'(ooo_pkg::rob_size));

    assign rob_val1.ready = in_use[rob_tag1] && done[rob_tag1];
    assign rob_val1.tag   = rob_tag1;
    assign rob_val1.value = value_q[rob_tag1];
    assign rob_val2.ready = in_use[rob_tag2] && done[rob_tag2];
    assign rob_val2.tag   = rob_tag2;
    assign rob_val2.value = value_q[rob_tag2];

    // in-order retire from head
    assign commit_valid = (count != '0) && done[head];
    assign commit.dest  = dest_q[head];
    assign commit.value = value_q[head];
    assign commit_tag   = head;

    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (alloc.valid) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (cdb.valid) begin
                done[cdb.tag] <= 1'b1;
            end
            if (commit_valid) begin
                head <= head + 1'b1;
            end
            case ({alloc.valid, commit_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc.valid) begin
            dest_q[tail] <= alloc.dest;
        end
        if (cdb.valid) begin
            value_q[cdb.tag] <= cdb.value;
        end
    end

    assert property (@(posedge clk) disable iff (reset) cdb.valid |-> in_use[cdb.tag]);

endmodule

//--- reservation_station.sv
`timescale 1ns/1ps

module reservation_station #(
    parameter int rs_depth = 4
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                entry_valid,
    input  ooo_pkg::rs_entry_t  entry,
    output logic                full,
    input  ooo_pkg::cdb_t       cdb,
    output logic                issue_valid,
    output ooo_pkg::exec_req_t  issue,
    input  logic                unit_ready
);

    localparam int idx_len = (rs_depth > 1) ? $clog2(rs_depth) : 1;

    // slot 0 holds the oldest entry, entries stay packed toward it
    logic [rs_depth-1:0] valid_q;
    logic [rs_depth-1:0] valid_d;
    logic [rs_depth-1:0] can_issue;
    ooo_pkg::rs_entry_t  ent_q [rs_depth];
    ooo_pkg::rs_entry_t  ent_d [rs_depth];
    ooo_pkg::rs_entry_t  woken [rs_depth];
    logic [idx_len-1:0]  pick;
    logic                found;
    logic                placed;

    function automatic ooo_pkg::operand_t wake(input ooo_pkg::operand_t src,
                                               input ooo_pkg::cdb_t     bus);
        ooo_pkg::operand_t res;
        res = src;
        if (!src.ready && bus.valid && bus.tag == src.tag) begin
            res.ready = 1'b1;
            res.value = bus.value;
        end
        return res;
    endfunction

    always_comb begin
        found = 1'b0;
        pick  = '0;
        for (int i = 0; i < rs_depth; i++) begin
            woken[i]      = ent_q[i];
            woken[i].src1 = wake(ent_q[i].src1, cdb);
            woken[i].src2 = wake(ent_q[i].src2, cdb);
            can_issue[i]  = valid_q[i] && ent_q[i].src1.ready && ent_q[i].src2.ready;
            if (can_issue[i] && !found) begin
                found = 1'b1;
                pick  = idx_len'(i);
            end
        end
    end

    assign full           = &valid_q;
    assign issue_valid    = found && unit_ready;
    assign issue.op       = ent_q[pick].op;
    assign issue.dest_tag = ent_q[pick].dest_tag;
    assign issue.val1     = ent_q[pick].src1.value;
    assign issue.val2     = ent_q[pick].src2.value;

    always_comb begin
        placed = 1'b0;
        for (int i = 0; i < rs_depth; i++) begin
            valid_d[i] = valid_q[i];
            ent_d[i]   = woken[i];
        end
        // close the gap left by the issued entry
        if (issue_valid) begin
            for (int i = 0; i < rs_depth - 1; i++) begin
                if (i >= int'(pick)) begin
                    valid_d[i] = valid_q[i + 1];
                    ent_d[i]   = woken[i + 1];
                end
            end
            valid_d[rs_depth - 1] = 1'b0;
        end
        for (int i = 0; i < rs_depth; i++) begin
            if (entry_valid && !valid_d[i] && !placed) begin
                valid_d[i] = 1'b1;
                ent_d[i]   = entry;
                placed     = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge clk) begin
        ent_q <= ent_d;
    end

    assert property (@(posedge clk) disable iff (reset) issue_valid |-> valid_q[0]);

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter real half_period = 2.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(half_period) clk = ~clk;

endmodule

//--- tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core;

    localparam int max_inst   = 64;
    localparam int max_test   = 16;
    localparam int wait_limit = 300;

    logic                   clk;
    logic                   reset;
    logic                   inst_valid;
    ooo_pkg::decoded_pack_t inst;
    logic                   inst_ready;
    logic                   commit_valid;
    ooo_pkg::commit_t       commit;

    // program as read from the stimulus file
    ooo_pkg::decoded_pack_t   prog [max_inst];
    logic [ooo_pkg::xlen-1:0] file_value [max_inst];
    int                       prog_test [max_inst];
    int                       prog_len;
    int                       test_size [max_test];
    int                       test_done [max_test];
    int                       test_errs [max_test];
    int                       test_stalls [max_test];

    logic [ooo_pkg::xlen-1:0] golden [ooo_pkg::reg_num];
    ooo_pkg::commit_t         exp_q [$];
    int                       exp_test_q [$];

    integer seed;
    int     errors;
    int     tests_run;
    int     total_stalls;
    bit     timed_out;

    tb_clock u_clock (
        .clk(clk)
    );

    ooo_core UUT (
        .clk(clk), .reset(reset),
        .inst_valid(inst_valid), .inst(inst), .inst_ready(inst_ready),
        .commit_valid(commit_valid), .commit(commit)
    );

    task automatic load_program();
        int          fd;
        int          n;
        string       line;
        logic [0:0]  fu_v;
        logic [2:0]  op_v;
        logic [3:0]  dest_v;
        logic [3:0]  src1_v;
        logic [3:0]  src2_v;
        logic [31:0] imm_v;
        logic        imm_valid_v;
        logic [31:0] exp_v;
        int          test_v;
        prog_len = 0;
        fd = $fopen("ooo_core_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file ooo_core_stimulus.txt");
            errors++;
            return;
        end
        while (!$feof(fd) && prog_len < max_inst) begin
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %d", fu_v, op_v, dest_v, src1_v,
                        src2_v, imm_v, imm_valid_v, exp_v, test_v);
            // comment and blank lines do not scan
            if (n == 9 && test_v >= 0 && test_v < max_test) begin
                prog[prog_len].fu        = ooo_pkg::fu_t'(fu_v);
                prog[prog_len].op        = ooo_pkg::alu_op_t'(op_v);
                prog[prog_len].dest      = dest_v;
                prog[prog_len].src1      = src1_v;
                prog[prog_len].src2      = src2_v;
                prog[prog_len].imm       = imm_v;
                prog[prog_len].imm_valid = imm_valid_v;
                file_value[prog_len]     = exp_v;
                prog_test[prog_len]      = test_v;
                test_size[test_v]++;
                prog_len++;
            end
        end
        $fclose(fd);
    endtask

    // reference result in program order
    function automatic logic [31:0] model_result(input ooo_pkg::decoded_pack_t d);
        logic [31:0] a;
        logic [31:0] b;
        a = golden[d.src1];
        b = d.imm_valid ? d.imm : golden[d.src2];
        case (d.op)
            ooo_pkg::op_add: return a + b;
            ooo_pkg::op_sub: return a - b;
            ooo_pkg::op_and: return a & b;
            ooo_pkg::op_or:  return a | b;
            ooo_pkg::op_xor: return a ^ b;
            ooo_pkg::op_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ooo_pkg::op_mul: return a * b;
            default:         return 32'd0;
        endcase
    endfunction

    task automatic queue_expected(input int i);
        ooo_pkg::commit_t want;
        want.dest  = prog[i].dest;
        want.value = model_result(prog[i]);
        if (want.value !== file_value[i]) begin
            $display("FAILED at %0t: file value of instruction %0d = %h, model = %h",
                     $time, i, file_value[i], want.value);
            errors++;
            test_errs[prog_test[i]]++;
        end
        golden[prog[i].dest] = want.value;
        exp_q.push_back(want);
        exp_test_q.push_back(prog_test[i]);
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic send_inst(input ooo_pkg::decoded_pack_t d, input int t);
        int waited;
        inst_valid = 1'b1;
        inst       = d;
        waited     = 0;
        while (!inst_ready && waited < wait_limit) begin
            test_stalls[t]++;
            total_stalls++;
            @(negedge clk);
            waited++;
        end
        if (!inst_ready) begin
            $display("timeout at %0t: inst_ready stayed low for %0d cycles", $time, waited);
            timed_out  = 1'b1;
            inst_valid = 1'b0;
        end else begin
            @(negedge clk);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < wait_limit) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout at %0t: %0d commits never arrived", $time, exp_q.size());
            timed_out = 1'b1;
        end else begin
            @(negedge clk);
        end
    endtask

    task automatic check_commit();
        ooo_pkg::commit_t want;
        int               t;
        if (exp_q.size() == 0) begin
            $display("unexpected commit at %0t with no instruction outstanding", $time);
            errors++;
            return;
        end
        want = exp_q.pop_front();
        t    = exp_test_q.pop_front();
        if (commit.dest !== want.dest) begin
            $display("FAILED at %0t: commit.dest = %h, expected %h",
                     $time, commit.dest, want.dest);
            errors++;
            test_errs[t]++;
        end
        if (commit.value !== want.value) begin
            $display("FAILED at %0t: commit.value = %h, expected %h",
                     $time, commit.value, want.value);
            errors++;
            test_errs[t]++;
        end
        test_done[t]++;
        if (test_done[t] == test_size[t]) begin
            $display("test %0d done: %0d commits, %0d errors, %0d stall cycles",
                     t, test_done[t], test_errs[t], test_stalls[t]);
        end
    endtask

    // one commit per cycle while commit_valid is high
    always @(negedge clk) begin
        if (!reset && commit_valid === 1'b1) begin
            check_commit();
        end
    end

    initial begin
        int gap;
        int cur_test;
        seed         = 32'h249a_087d;
        errors       = 0;
        tests_run    = 0;
        total_stalls = 0;
        timed_out    = 1'b0;
        reset        = 1'b1;
        inst_valid   = 1'b0;
        inst         = '0;
        for (int r = 0; r < ooo_pkg::reg_num; r++) begin
            golden[r] = '0;
        end
        for (int t = 0; t < max_test; t++) begin
            test_size[t]   = 0;
            test_done[t]   = 0;
            test_errs[t]   = 0;
            test_stalls[t] = 0;
        end
        load_program();
        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if (inst_ready !== 1'b1) begin
            $display("FAILED at %0t: inst_ready = %b, expected %b", $time, inst_ready, 1'b1);
            errors++;
        end
        cur_test = -1;
        for (int i = 0; i < prog_len && !timed_out; i++) begin
            // each test starts on an empty core after a short idle gap
            if (prog_test[i] != cur_test) begin
                inst_valid = 1'b0;
                wait_drain();
                gap = $unsigned($random(seed)) % 4;
                repeat (gap) @(negedge clk);
                cur_test = prog_test[i];
                tests_run++;
            end
            if (!timed_out) begin
                queue_expected(i);
                send_inst(prog[i], cur_test);
            end
        end
        inst_valid = 1'b0;
        if (!timed_out) begin
            wait_drain();
        end
        if (total_stalls == 0) begin
            $display("inst_ready never dropped, so back-pressure was not exercised");
            errors++;
        end
        $display("summary: %0d tests, %0d instructions, %0d errors, %0d stall cycles",
                 tests_run, prog_len, errors, total_stalls);
        if (errors == 0 && !timed_out && prog_len > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
